//--- Bender.yml
package:
  name: r5p_mini

sources:
  - hw/r5p_isa_pkg.sv
  - hw/r5p_bus_pkg.sv
  - hw/r5p_gpr_1r1w.sv
  - hw/r5p_axil_front.sv
  - hw/r5p_alu_exec.sv
  - hw/r5p_mini_top.sv
  - target: test
    files:
      - tb/r5p_mini_tb.sv

//--- filelist.f
hw/r5p_isa_pkg.sv
hw/r5p_bus_pkg.sv
hw/r5p_gpr_1r1w.sv
hw/r5p_axil_front.sv
hw/r5p_alu_exec.sv
hw/r5p_mini_top.sv
tb/r5p_mini_tb.sv

//--- hw/r5p_alu_exec.sv
/* Execute stage for the immediate ALU ops and LUI. The issued word is decoded,
   the result computed from rs1 and held one cycle in the writeback register. */
`timescale 1ns/1ns

module r5p_alu_exec (
  input  logic                           clk,
  input  logic                           arst_n,
  // issue
  input  logic                           issue_valid,
  input  r5p_isa_pkg::r5p_inst_t         issue_inst,
  input  logic [r5p_isa_pkg::xlen-1:0]   rs_data,  // rs1 value, bypassed
  // writeback
  output logic                           wb_valid,
  output logic [r5p_isa_pkg::gpr_aw-1:0] wb_rd,
  output logic [r5p_isa_pkg::xlen-1:0]   wb_data
);

  import r5p_isa_pkg::*;

  logic [xlen-1:0] imm;     // sign extended imm12
  logic [4:0]      shamt;
  logic [xlen-1:0] result;

  assign imm   = {{(xlen-12){issue_inst.i.imm12[11]}}, issue_inst.i.imm12};
  assign shamt = issue_inst.i.imm12[4:0];

  ////////////////////
  // alu
  ////////////////////

  always_comb begin
    if (issue_inst.u.opcode == opc_lui) begin
      result = {issue_inst.u.imm20, 12'd0};
    end else begin
      case (issue_inst.i.funct3)
        f3_addi: result = rs_data + imm;
        f3_xori: result = rs_data ^ imm;
        f3_ori:  result = rs_data | imm;
        f3_andi: result = rs_data & imm;
        f3_slli: result = rs_data << shamt;
        f3_srli: result = rs_data >> shamt;  // logical
        default: result = '0;  // filtered out by the front end
      endcase
    end
  end

  ////////////////////
  // writeback register
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= issue_valid;  // one write per issue
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      wb_rd   <= issue_inst.i.rd[gpr_aw-1:0];  // rd at same place for lui
      wb_data <= result;
    end
  end

endmodule

//--- hw/r5p_axil_front.sv
/* AXI4-Lite slave front end. Instruction writes are checked and moved into the issue
   register, reads return a register file word through the register window. */
`timescale 1ns/1ns

module r5p_axil_front (
  input  logic                             clk,
  input  logic                             arst_n,
  // write address
  input  logic                             awvalid,
  output logic                             awready,
  input  logic [r5p_bus_pkg::axil_aw-1:0]  awaddr,
  // write data
  input  logic                             wvalid,
  output logic                             wready,
  input  logic [r5p_isa_pkg::xlen-1:0]     wdata,
  input  logic [r5p_isa_pkg::xlen/8-1:0]   wstrb,   // whole-word instructions, not decoded
  // write response
  output logic                             bvalid,
  input  logic                             bready,
  output logic [1:0]                       bresp,
  // read address
  input  logic                             arvalid,
  output logic                             arready,
  input  logic [r5p_bus_pkg::axil_aw-1:0]  araddr,
  // read data
  output logic                             rvalid,
  input  logic                             rready,
  output logic [r5p_isa_pkg::xlen-1:0]     rdata,
  output logic [1:0]                       rresp,
  // register file read port
  output logic [r5p_isa_pkg::gpr_aw-1:0]   rs_addr,
  input  logic [r5p_isa_pkg::xlen-1:0]     rs_data,
  // issue register
  output logic                             issue_valid,
  output r5p_isa_pkg::r5p_inst_t           issue_inst
);

  import r5p_isa_pkg::*;
  import r5p_bus_pkg::*;

  r5p_inst_t w_inst;   // write data seen as instruction
  logic      idle;     // nothing issued, no response outstanding
  logic      aw_hs;    // joint aw/w transfer
  logic      ar_hs;
  logic      inst_ok;  // supported encoding
  logic      wr_ok;    // supported and at the instruction address
  logic      ar_hit;   // inside register window

  assign w_inst = wdata;

  ////////////////////
  // handshakes
  ////////////////////

  assign idle = ~issue_valid & ~bvalid & ~rvalid;

  // aw and w only taken together, so ready waits for both valids
  assign awready = idle & awvalid & wvalid;
  assign wready  = awready;
  assign arready = idle & arvalid;

  assign aw_hs = awvalid & wvalid & awready;
  assign ar_hs = arvalid & arready;

  ////////////////////
  // decode
  ////////////////////

  always_comb begin
    inst_ok = 1'b0;
    if (w_inst.u.opcode == opc_lui) begin
      inst_ok = 1'b1;
    end else if (w_inst.i.opcode == opc_op_imm) begin
      case (w_inst.i.funct3)
        f3_addi, f3_xori, f3_ori, f3_andi: inst_ok = 1'b1;
        f3_slli, f3_srli: inst_ok = (w_inst.i.imm12[11:5] == 7'd0); // no srai
        default: inst_ok = 1'b0;  // slti, sltiu
      endcase
    end
  end

  assign wr_ok  = (awaddr == addr_inst) && inst_ok;
  assign ar_hit = (araddr & ~gpr_win_mask) == addr_gpr_base; // also rejects unaligned

  // issued rs1 has priority, otherwise the word index of the read address
  assign rs_addr = issue_valid ? issue_inst.i.rs1[gpr_aw-1:0] : araddr[gpr_aw+1:2];

  ////////////////////
  // control registers
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
      bvalid      <= 1'b0;
      rvalid      <= 1'b0;
    end else begin
      issue_valid <= aw_hs & wr_ok;  // execute is always ready, one cycle here
      if (aw_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (ar_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  ////////////////////
  // payload registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      bresp <= wr_ok ? resp_okay : resp_slverr;
      if (wr_ok) begin
        issue_inst <= w_inst;
      end
    end
    if (ar_hs) begin
      rdata <= ar_hit ? rs_data : '0;   // value at acceptance, bypass included
      rresp <= ar_hit ? resp_okay : resp_slverr;
    end
  end

endmodule

//--- hw/r5p_bus_pkg.sv
/* AXI4-Lite constants for the subsystem front end.
   Address width, address map of the instruction port and register window, responses. */
package r5p_bus_pkg;

  ////////////////////
  // address map
  ////////////////////

  localparam int unsigned axil_aw = 8;

  localparam logic [axil_aw-1:0] addr_inst = 8'h00; // instruction write port

  // register window, xN at base + 4*N
  localparam logic [axil_aw-1:0] addr_gpr_base = 8'h80;
  localparam logic [axil_aw-1:0] gpr_win_mask  = 8'h7c; // index bits inside window

  ////////////////////
  // responses
  ////////////////////

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- hw/r5p_gpr_1r1w.sv
/* General purpose register file, one combinational read port and one write port.
   x0 is never written; a read of the register being written returns the new data. */
`timescale 1ns/1ns

module r5p_gpr_1r1w #(
  int unsigned aw = r5p_isa_pkg::gpr_aw  // 4 is enough for rv32e
)(
  input  logic                         clk,
  // write port
  input  logic                         e_rd,
  input  logic [aw-1:0]                a_rd,
  input  logic [r5p_isa_pkg::xlen-1:0] d_rd,
  // read port
  input  logic [aw-1:0]                a_rs,
  output logic [r5p_isa_pkg::xlen-1:0] d_rs
);

  import r5p_isa_pkg::*;

  logic            wen;   // qualified write enable
  logic [xlen-1:0] t_rs;  // raw array read

  // plain array, powers up cleared, so x0 reads zero
  logic [xlen-1:0] gpr [0:2**aw-1] = '{default: '0};

  // x0 stays zero
  assign wen = e_rd & (|a_rd);

  ////////////////////
  // array
  ////////////////////

  always_ff @(posedge clk) begin
    if (wen) begin
      gpr[a_rd] <= d_rd;
    end
  end

  assign t_rs = gpr[a_rs];  // combinational read

  ////////////////////
  // write bypass
  ////////////////////

  // result still on its way into the array wins over the stale entry
  assign d_rs = (wen && (a_rd == a_rs)) ? d_rd : t_rs;

endmodule

//--- hw/r5p_isa_pkg.sv
/* RV32 subset encodings for the register-file/execute subsystem.
   Opcodes, funct3 codes, register file sizes and the instruction word union. */
package r5p_isa_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int unsigned xlen   = 32; // data word
  localparam int unsigned gpr_aw = 5;  // 32 registers, 4 would do for rv32e

  ////////////////////
  // opcodes
  ////////////////////

  localparam logic [6:0] opc_op_imm = 7'b0010011; // immediate alu ops
  localparam logic [6:0] opc_lui    = 7'b0110111; // load upper immediate

  ////////////////////
  // funct3 for op_imm
  ////////////////////

  localparam logic [2:0] f3_addi = 3'b000;
  localparam logic [2:0] f3_slli = 3'b001; // needs funct7 zero
  localparam logic [2:0] f3_xori = 3'b100;
  localparam logic [2:0] f3_srli = 3'b101; // funct7 zero, 0x20 would be srai
  localparam logic [2:0] f3_ori  = 3'b110;
  localparam logic [2:0] f3_andi = 3'b111;

  ////////////////////
  // instruction word
  ////////////////////

  // same 32 bits seen as I-type or U-type
  // opcode and rd sit at the same place in both
  typedef union packed {
    struct packed {
      logic [11:0] imm12;  // signed immediate, shamt in low bits
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [19:0] imm20;  // upper immediate
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } r5p_inst_t;

endpackage

//--- hw/r5p_mini_top.sv
/* Top of the register-file/execute subsystem. AXI4-Lite front end feeds the
   execute stage, both share the register file through one read and one write port. */
`timescale 1ns/1ns

module r5p_mini_top (
  input  logic                            clk,
  input  logic                            arst_n,
  // write address
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [r5p_bus_pkg::axil_aw-1:0] awaddr,
  // write data
  input  logic                            wvalid,
  output logic                            wready,
  input  logic [r5p_isa_pkg::xlen-1:0]    wdata,
  input  logic [r5p_isa_pkg::xlen/8-1:0]  wstrb,
  // write response
  output logic                            bvalid,
  input  logic                            bready,
  output logic [1:0]                      bresp,
  // read address
  input  logic                            arvalid,
  output logic                            arready,
  input  logic [r5p_bus_pkg::axil_aw-1:0] araddr,
  // read data
  output logic                            rvalid,
  input  logic                            rready,
  output logic [r5p_isa_pkg::xlen-1:0]    rdata,
  output logic [1:0]                      rresp
);

  import r5p_isa_pkg::*;

  logic              issue_valid;
  r5p_inst_t         issue_inst;
  logic [gpr_aw-1:0] rs_addr;   // read port, shared by issue and bus reads
  logic [xlen-1:0]   rs_data;
  logic              wb_valid;  // write port
  logic [gpr_aw-1:0] wb_rd;
  logic [xlen-1:0]   wb_data;

  r5p_axil_front front_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .awvalid     (awvalid),
    .awready     (awready),
    .awaddr      (awaddr),
    .wvalid      (wvalid),
    .wready      (wready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .bvalid      (bvalid),
    .bready      (bready),
    .bresp       (bresp),
    .arvalid     (arvalid),
    .arready     (arready),
    .araddr      (araddr),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rs_addr     (rs_addr),
    .rs_data     (rs_data),
    .issue_valid (issue_valid),
    .issue_inst  (issue_inst)
  );

  r5p_gpr_1r1w #(
    .aw (gpr_aw)
  ) gpr_i (
    .clk  (clk),
    .e_rd (wb_valid),
    .a_rd (wb_rd),
    .d_rd (wb_data),
    .a_rs (rs_addr),
    .d_rs (rs_data)
  );

  r5p_alu_exec exec_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue_inst  (issue_inst),
    .rs_data     (rs_data),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

endmodule

//--- tb/r5p_mini_tb.sv
/* Testbench for the register-file/execute subsystem. Drives AXI4-Lite writes and reads,
   predicts register contents with a reference model and checks by assertions. */
`timescale 1ns/1ns

module r5p_mini_tb;

  import r5p_isa_pkg::*;
  import r5p_bus_pkg::*;

  localparam int n_rand  = 20;  // random instruction + readback pairs
  localparam int n_b2b   = 8;   // dependent instruction pairs
  localparam int n_trans = 1 + 2*n_rand + 3*n_b2b + 4 + 5 + 34;
  localparam int max_cyc = 40 * n_trans;

  logic clk = 1'b0;
  logic arst_n;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [axil_aw-1:0] awaddr, araddr;
  logic [xlen-1:0]    wdata, rdata;
  logic [xlen/8-1:0]  wstrb;
  logic [1:0]         bresp, rresp;

  logic [xlen-1:0] model [0:31];  // reference register values
  logic [15:0]     lfsr = 16'd65;
  int              cycles = 0;

  always #10 clk = ~clk;

  r5p_mini_top dut_i (.*);

  ////////////////////
  // failure reporting
  ////////////////////

  task automatic fail_now();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic stop_run(input string what);
    $display("ERROR at %0t: %s", $time, what);
    fail_now();
  endtask

  task automatic mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
    $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
    fail_now();
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > max_cyc) begin  // run never finished
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      fail_now();
    end
  end

  ////////////////////
  // protocol checks
  ////////////////////

  // held response keeps its payload
  ap_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else stop_run("write response dropped or changed while bready low");
  ap_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else stop_run("read response dropped or changed while rready low");
  // pending response blocks new addresses
  ap_busy: assert property (@(posedge clk) disable iff (!arst_n)
    (bvalid || rvalid) |-> !awready && !wready && !arready)
    else stop_run("address accepted while a response was pending");
  // responses only follow a real handshake
  ap_b_cause: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
    else stop_run("bvalid rose without a write handshake");
  ap_r_cause: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(rvalid) |-> $past(arvalid && arready))
    else stop_run("rvalid rose without a read handshake");

  ////////////////////
  // lfsr and reference
  ////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  function automatic logic supported(input logic [31:0] w);
    if (w[6:0] == opc_lui) return 1'b1;
    if (w[6:0] != opc_op_imm) return 1'b0;
    case (w[14:12])
      f3_addi, f3_xori, f3_ori, f3_andi: return 1'b1;
      f3_slli, f3_srli: return w[31:25] == 7'd0;  // srai excluded
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] ref_result(input logic [31:0] w, input logic [31:0] a);
    logic [31:0] sx;
    sx = {{20{w[31]}}, w[31:20]};
    if (w[6:0] == opc_lui) return {w[31:12], 12'h000};
    case (w[14:12])
      f3_addi: return a + sx;
      f3_xori: return a ^ sx;
      f3_ori:  return a | sx;
      f3_andi: return a & sx;
      f3_slli: return a << w[24:20];
      default: return a >> w[24:20];  // srli
    endcase
  endfunction

  ////////////////////
  // bus driver tasks
  ////////////////////

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input int stall, output logic [1:0] resp);
    @(negedge clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    bready  = 1'b0;
    do @(posedge clk); while (!(awready && wready));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    assert (bvalid) else stop_run("bvalid missing one cycle after write handshake");
    resp = bresp;
    repeat (stall) begin  // back-pressure, every address channel requests
      awvalid = 1'b1;
      wvalid  = 1'b1;
      arvalid = 1'b1;
      @(negedge clk);
      assert (bvalid && bresp === resp && !awready && !wready && !arready)
        else stop_run("write channel not stalled under back-pressure");
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    bready  = 1'b1;
    @(posedge clk);
  endtask

  task automatic axil_read(input logic [7:0] addr, input int stall,
                           output logic [31:0] data, output logic [1:0] resp);
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    rready  = 1'b0;
    do @(posedge clk); while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    assert (rvalid) else stop_run("rvalid missing one cycle after read handshake");
    data = rdata;
    resp = rresp;
    repeat (stall) begin  // pending read must block all address channels
      awvalid = 1'b1;
      wvalid  = 1'b1;
      arvalid = 1'b1;
      @(negedge clk);
      assert (rvalid && rdata === data && rresp === resp && !awready && !wready && !arready)
        else stop_run("read channel not stalled under back-pressure");
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(posedge clk);
  endtask

  ////////////////////
  // test steps
  ////////////////////

  task automatic run_inst(input logic [7:0] addr, input logic [31:0] w);
    logic [31:0] stall;
    logic [1:0]  resp, exp;
    take_bits(3, stall);
    exp = (addr == addr_inst && supported(w)) ? resp_okay : resp_slverr;
    if (exp == resp_okay && w[11:7] != 5'd0)
      model[w[11:7]] = ref_result(w, model[w[19:15]]);  // rs1 value before write
    axil_write(addr, w, stall, resp);
    assert (resp === exp) else mismatch("bresp", exp, resp);
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [31:0] exp_d,
                            input logic [1:0] exp_r);
    logic [31:0] stall, d;
    logic [1:0]  r;
    take_bits(3, stall);
    axil_read(addr, stall, d, r);
    assert (r === exp_r) else mismatch("rresp", exp_r, r);
    assert (d === exp_d) else mismatch("rdata", exp_d, d);
  endtask

  task automatic check_reg(input logic [4:0] n);
    check_read(addr_gpr_base + {n, 2'b00}, model[n], resp_okay);
  endtask

  task automatic rand_inst(output logic [31:0] w);
    logic [31:0] k, rd, rs1, imm, imm20;
    take_bits(3, k);
    take_bits(5, rd);
    take_bits(5, rs1);
    take_bits(12, imm);
    take_bits(20, imm20);
    case (k)
      0: w = {imm[11:0], rs1[4:0], f3_addi, rd[4:0], opc_op_imm};
      1: w = {imm[11:0], rs1[4:0], f3_xori, rd[4:0], opc_op_imm};
      2: w = {imm[11:0], rs1[4:0], f3_ori, rd[4:0], opc_op_imm};
      3: w = {imm[11:0], rs1[4:0], f3_andi, rd[4:0], opc_op_imm};
      4: w = {7'd0, imm[4:0], rs1[4:0], f3_slli, rd[4:0], opc_op_imm};
      5: w = {7'd0, imm[4:0], rs1[4:0], f3_srli, rd[4:0], opc_op_imm};
      default: w = {imm20[19:0], rd[4:0], opc_lui};
    endcase
  endtask

  initial begin
    logic [31:0] w1, w2, v;
    foreach (model[i]) model[i] = '0;
    arst_n  = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    bready  = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = 4'hf;  // whole words only
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    assert (!awready && !wready && !arready && !bvalid && !rvalid
            && !dut_i.issue_valid && !dut_i.wb_valid)
      else stop_run("valid or ready output high right after reset");

    // random supported ops, each rd read back
    repeat (n_rand) begin
      rand_inst(w1);
      run_inst(addr_inst, w1);
      check_reg(w1[11:7]);
    end

    // rs1 of the second op is rd of the first
    repeat (n_b2b) begin
      rand_inst(w1);
      if (w1[11:7] == 5'd0) w1[11:7] = 5'd1;
      run_inst(addr_inst, w1);
      take_bits(17, v);
      w2 = {v[11:0], w1[11:7], f3_addi, v[16:12], opc_op_imm};
      if (w2[11:7] == 5'd0) w2[11:7] = 5'd2;  // result must land somewhere visible
      run_inst(addr_inst, w2);
      check_reg(w2[11:7]);
    end

    // x0 as target and as source
    run_inst(addr_inst, {12'h123, 5'd3, f3_addi, 5'd0, opc_op_imm});
    check_reg(5'd0);
    run_inst(addr_inst, {12'h5a5, 5'd0, f3_ori, 5'd9, opc_op_imm});
    check_reg(5'd9);

    // rejected writes, nothing may change
    run_inst(addr_inst, {12'h001, 5'd1, 3'b010, 5'd2, opc_op_imm});  // slti
    run_inst(addr_inst, {12'h004, 5'd1, 3'b010, 5'd2, 7'b0000011});  // load
    run_inst(addr_inst, {7'h20, 5'd3, 5'd1, f3_srli, 5'd4, opc_op_imm});  // srai
    run_inst(8'h04, {12'h00f, 5'd1, f3_addi, 5'd5, opc_op_imm});
    run_inst(8'h80, {12'h00f, 5'd1, f3_addi, 5'd6, opc_op_imm});
    for (int n = 0; n < 32; n++) check_reg(n[4:0]);

    // reads outside the window
    check_read(8'h40, 32'h0, resp_slverr);
    check_read(8'h82, 32'h0, resp_slverr);  // unaligned

    @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule
